// File: rtl/cpu_ctl_pkg.sv
package cpu_ctl_pkg;

    typedef enum logic [5:0] {
        INIT, SYNC, IMM0, IND0, IND1, IND2, DATA,   // Fetch and operand addressing
        ABS0, ABS1, ZERO, PULL, RDWR,               // Absolute, zero page, stack read
        RTS0, RTS1, RTS2, PUSH, JSR0, JSR1, JSR2,   // Subroutine and stack write
        COND                                        // Relative branch
    } ctl_state_t;

    typedef logic [7:0]  opcode_t;    // Data bus byte
    typedef logic [3:0]  ab_mode_t;   // Bits 1:0 ABL select and bit 2 ABL carry
    typedef logic [11:0] ab_op_t;     // Hold/ABH ctl, ABL select, ABL op, carry
    typedef logic [6:0]  reg_op_t;    // Write, dst, src
    typedef logic [3:0]  reg_src_t;
    typedef logic [1:0]  reg_dst_t;
    typedef logic [6:0]  alu_fn_t;    // Shift, add, carry
    typedef logic [8:0]  alu_op_t;    // Load M, BCD, function

    typedef enum logic [1:0] {
        DO_ALU = 2'd0,
        DO_P   = 2'd1,                // Status register, kept for the datapath mux
        DO_PCL = 2'd2,
        DO_PCH = 2'd3
    } do_sel_t;

    localparam reg_src_t SRC_X = 4'd0;
    localparam reg_src_t SRC_Y = 4'd1;
    localparam reg_src_t SRC_A = 4'd2;
    localparam reg_src_t SRC_S = 4'd3;
    localparam reg_src_t SRC_M = 4'd5;
    localparam reg_src_t SRC_Z = 4'd7;   // Constant zero

    localparam reg_dst_t DST_X = 2'd0;
    localparam reg_dst_t DST_Y = 2'd1;
    localparam reg_dst_t DST_A = 2'd2;
    localparam reg_dst_t DST_S = 2'd3;

    localparam alu_fn_t ALU_FN_OR   = 7'b00_000_00;
    localparam alu_fn_t ALU_FN_AND  = 7'b00_001_00;
    localparam alu_fn_t ALU_FN_XOR  = 7'b00_010_00;
    localparam alu_fn_t ALU_FN_LOAD = 7'b00_011_00;   // Add zero, pass through
    localparam alu_fn_t ALU_FN_ADC  = 7'b00_011_11;
    localparam alu_fn_t ALU_FN_SBC  = 7'b00_110_11;
    localparam alu_fn_t ALU_FN_CMP  = 7'b00_110_01;   // Subtract with carry forced
    localparam alu_fn_t ALU_FN_INC  = 7'b00_100_01;
    localparam alu_fn_t ALU_FN_DEC  = 7'b00_101_00;
    localparam alu_fn_t ALU_FN_ASL  = 7'b10_011_00;
    localparam alu_fn_t ALU_FN_DC   = 7'b11_111_11;   // Unlisted opcode

    localparam alu_op_t STACK_DEC    = 9'b00_00_101_00;
    localparam alu_op_t STACK_INC    = 9'b00_00_100_01;
    localparam alu_op_t ALU_OP_LDM   = 9'b10_00_000_00;
    localparam alu_op_t ALU_OP_STORE = 9'b00_00_100_00;
    localparam alu_op_t ALU_OP_NOP   = 9'b00_00_000_00;

    localparam opcode_t OP_ASL_ZP   = 8'h06;
    localparam opcode_t OP_ORA_IMM  = 8'h09;
    localparam opcode_t OP_ASL_ZPX  = 8'h16;
    localparam opcode_t OP_JSR      = 8'h20;
    localparam opcode_t OP_AND_IMM  = 8'h29;
    localparam opcode_t OP_PHA      = 8'h48;
    localparam opcode_t OP_EOR_IMM  = 8'h49;
    localparam opcode_t OP_JMP_ABS  = 8'h4c;
    localparam opcode_t OP_RTS      = 8'h60;
    localparam opcode_t OP_ADC_ZP   = 8'h65;
    localparam opcode_t OP_PLA      = 8'h68;
    localparam opcode_t OP_ADC_IMM  = 8'h69;
    localparam opcode_t OP_JMP_IND  = 8'h6c;
    localparam opcode_t OP_JMP_INDX = 8'h7c;
    localparam opcode_t OP_BRA      = 8'h80;
    localparam opcode_t OP_LDY_IMM  = 8'ha0;
    localparam opcode_t OP_LDA_INDX = 8'ha1;
    localparam opcode_t OP_LDX_IMM  = 8'ha2;
    localparam opcode_t OP_LDA_ZP   = 8'ha5;
    localparam opcode_t OP_LDA_IMM  = 8'ha9;
    localparam opcode_t OP_LDA_ABS  = 8'had;
    localparam opcode_t OP_LDA_INDY = 8'hb1;
    localparam opcode_t OP_LDA_IND  = 8'hb2;
    localparam opcode_t OP_LDA_ZPX  = 8'hb5;
    localparam opcode_t OP_LDX_ZPY  = 8'hb6;
    localparam opcode_t OP_LDA_ABSY = 8'hb9;
    localparam opcode_t OP_LDA_ABSX = 8'hbd;
    localparam opcode_t OP_CMP_IMM  = 8'hc9;
    localparam opcode_t OP_DEX      = 8'hca;
    localparam opcode_t OP_INC_ZP   = 8'he6;
    localparam opcode_t OP_INX      = 8'he8;
    localparam opcode_t OP_SBC_IMM  = 8'he9;
    localparam opcode_t OP_INC_ABS  = 8'hee;

endpackage

// File: rtl/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import cpu_ctl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  opcode_t    db,            // Opcode while in SYNC
    input  logic       sync,
    input  logic       abs1_done,     // One address pass finished
    output ctl_state_t entry_state,
    output logic       rmw,
    output logic       jmp,
    output logic       ind,
    output logic       add_x,
    output logic       add_y,
    output logic       ld,
    output logic       st,
    output reg_src_t   src,
    output reg_dst_t   dst,
    output alu_fn_t    alu_fn
);

    reg_src_t src_dec;
    reg_dst_t dst_dec;
    alu_fn_t  alu_dec;

    always_comb begin
        case (db)
            OP_BRA:  entry_state = COND;
            OP_JSR:  entry_state = JSR0;
            OP_RTS:  entry_state = RTS0;
            OP_PHA:  entry_state = PUSH;
            OP_PLA:  entry_state = PULL;
            OP_JMP_ABS, OP_JMP_IND, OP_JMP_INDX, OP_INC_ABS,
            OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY:                   entry_state = ABS0;
            OP_ASL_ZP, OP_ASL_ZPX, OP_INC_ZP, OP_ADC_ZP,
            OP_LDA_ZP, OP_LDA_ZPX, OP_LDX_ZPY:                      entry_state = ZERO;
            OP_LDA_INDX, OP_LDA_IND, OP_LDA_INDY:                   entry_state = IND0;
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ORA_IMM,
            OP_AND_IMM, OP_EOR_IMM, OP_ADC_IMM, OP_SBC_IMM,
            OP_CMP_IMM:                                             entry_state = IMM0;
            default: entry_state = SYNC;                            // One-cycle no-op
        endcase
    end

    always_comb begin
        case (db)
            OP_DEX, OP_INX:                                         src_dec = SRC_X;
            OP_PHA, OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM, OP_ADC_IMM,
            OP_SBC_IMM, OP_CMP_IMM, OP_ADC_ZP:                      src_dec = SRC_A;
            OP_INC_ZP, OP_INC_ABS, OP_ASL_ZP, OP_ASL_ZPX:           src_dec = SRC_M;
            default:                                                src_dec = SRC_Z;
        endcase
        case (db)
            OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY,
            OP_LDA_INDX, OP_LDA_IND, OP_LDA_INDY, OP_PLA,
            OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM, OP_ADC_IMM,
            OP_SBC_IMM, OP_CMP_IMM, OP_ADC_ZP:                      dst_dec = DST_A;
            OP_LDY_IMM:                                             dst_dec = DST_Y;
            default:                                                dst_dec = DST_X;
        endcase
        case (db)
            OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY,
            OP_LDA_INDX, OP_LDA_IND, OP_LDA_INDY, OP_LDX_IMM, OP_LDX_ZPY,
            OP_LDY_IMM, OP_PHA, OP_PLA:                             alu_dec = ALU_FN_LOAD;
            OP_DEX:                                                 alu_dec = ALU_FN_DEC;
            OP_INX, OP_INC_ZP, OP_INC_ABS:                          alu_dec = ALU_FN_INC;
            OP_ASL_ZP, OP_ASL_ZPX:                                  alu_dec = ALU_FN_ASL;
            OP_ORA_IMM:                                             alu_dec = ALU_FN_OR;
            OP_AND_IMM:                                             alu_dec = ALU_FN_AND;
            OP_EOR_IMM:                                             alu_dec = ALU_FN_XOR;
            OP_ADC_IMM, OP_ADC_ZP:                                  alu_dec = ALU_FN_ADC;
            OP_SBC_IMM:                                             alu_dec = ALU_FN_SBC;
            OP_CMP_IMM:                                             alu_dec = ALU_FN_CMP;
            default:                                                alu_dec = ALU_FN_DC;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rmw    <= 1'b0;
            jmp    <= 1'b0;
            ind    <= 1'b0;
            add_x  <= 1'b0;
            add_y  <= 1'b0;
            ld     <= 1'b0;
            st     <= 1'b0;
            src    <= '0;
            dst    <= '0;
            alu_fn <= '0;
        end else if (sync) begin
            rmw    <= db inside {OP_ASL_ZP, OP_ASL_ZPX, OP_INC_ZP, OP_INC_ABS};
            jmp    <= db inside {OP_JSR, OP_RTS, OP_JMP_ABS, OP_JMP_IND, OP_JMP_INDX};
            ind    <= db inside {OP_JMP_IND, OP_JMP_INDX};   // Extra pass through ABS0
            add_x  <= db inside {OP_JMP_INDX, OP_LDA_ZPX, OP_LDA_ABSX, OP_LDA_INDX,
                                 OP_ASL_ZPX};
            add_y  <= db inside {OP_LDA_INDY, OP_LDX_ZPY, OP_LDA_ABSY};
            ld     <= (dst_dec == DST_A && db != OP_CMP_IMM) || alu_dec == ALU_FN_DEC ||
                      db inside {OP_LDX_IMM, OP_LDX_ZPY, OP_LDY_IMM, OP_INX};
            st     <= (db == OP_PHA);
            src    <= src_dec;
            dst    <= dst_dec;
            alu_fn <= alu_dec;
        end else if (abs1_done) begin
            ind    <= 1'b0;                       // Stop looping on indirection
            add_x  <= 1'b0;                       // X only applies to the pointer
        end
    end

    // Indirection only exists for jumps
    assert property (@(posedge clk) disable iff (reset) ind |-> jmp);

endmodule

// File: rtl/ctl_sequencer.sv
`timescale 1ns/10ps

module ctl_sequencer import cpu_ctl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ctl_state_t entry_state,   // First state of the fetched opcode
    input  logic       ind,
    input  logic       jmp,
    input  logic       rmw,
    output ctl_state_t state,
    output logic       sync,          // Opcode fetch cycle
    output logic       abs1_done
);

    ctl_state_t state_nxt;

    assign sync      = (state == SYNC);
    assign abs1_done = (state == ABS1);

    always_comb begin
        case (state)
            INIT:    state_nxt = SYNC;
            SYNC:    state_nxt = entry_state;
            IMM0:    state_nxt = SYNC;
            IND0:    state_nxt = IND1;               // Pointer low
            IND1:    state_nxt = IND2;               // Pointer high
            IND2:    state_nxt = DATA;
            ABS0:    state_nxt = ABS1;
            ZERO:    state_nxt = rmw ? RDWR : DATA;
            ABS1: begin
                if (ind)
                    state_nxt = ABS0;                // Fetch target through pointer
                else if (jmp)
                    state_nxt = SYNC;
                else
                    state_nxt = rmw ? RDWR : DATA;
            end
            RDWR:    state_nxt = DATA;               // Write back old value
            DATA:    state_nxt = SYNC;
            PULL:    state_nxt = DATA;
            PUSH:    state_nxt = DATA;
            RTS0:    state_nxt = RTS1;
            RTS1:    state_nxt = RTS2;
            RTS2:    state_nxt = SYNC;
            JSR0:    state_nxt = JSR1;
            JSR1:    state_nxt = JSR2;
            JSR2:    state_nxt = ABS1;               // Target high byte
            COND:    state_nxt = SYNC;
            default: state_nxt = SYNC;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= INIT;
        else
            state <= state_nxt;
    end

    // INIT only ever follows reset
    assert property (@(posedge clk) disable iff (reset) state != INIT |=> state != INIT);
    // Decoder ends the pointer pass after one loop
    assert property (@(posedge clk) disable iff (reset) abs1_done && ind |=> !ind);

endmodule

// File: rtl/addr_op_gen.sv
`timescale 1ns/10ps

module addr_op_gen import cpu_ctl_pkg::*; (
    input  ctl_state_t state,
    input  logic       cond,          // Branch taken
    input  opcode_t    db,            // Branch offset in COND
    output ab_op_t     ab_op
);

    ab_mode_t mode;
    logic     back;

    assign back = cond & db[7];                          // Taken with negative offset

    always_comb begin
        case (state)
            INIT:    mode = 4'd0;
            SYNC:    mode = 4'd4;
            IMM0:    mode = 4'd4;
            IND0:    mode = 4'd3;
            IND1:    mode = 4'd12;
            IND2:    mode = 4'd10;
            DATA:    mode = 4'd1;
            ABS0:    mode = 4'd4;
            ABS1:    mode = 4'd2;
            ZERO:    mode = 4'd3;
            PULL:    mode = 4'd5;
            RDWR:    mode = 4'd0;
            RTS0:    mode = 4'd5;
            RTS1:    mode = 4'd5;
            RTS2:    mode = 4'd14;
            PUSH:    mode = 4'd11;
            JSR0:    mode = 4'd9;
            JSR1:    mode = 4'd8;
            JSR2:    mode = 4'd1;
            COND:    mode = 4'd7;
            default: mode = 4'd0;
        endcase
    end

    always_comb begin
        case (mode)
            4'd1:  ab_op = {7'b000_1010, mode[1:0], 2'b10, mode[2]};   // PC
            4'd2:  ab_op = {7'b111_1110, mode[1:0], 2'b01, mode[2]};   // {DB, AHL+REG}
            4'd3:  ab_op = {7'b111_0000, mode[1:0], 2'b01, mode[2]};   // {00, DB+REG}
            4'd4:  ab_op = {7'b011_0110, mode[1:0], 2'b11, mode[2]};   // AB+1, store PC
            4'd5:  ab_op = {7'b011_0001, mode[1:0], 2'b00, mode[2]};   // {01, SP+1}
            4'd7: begin
                if (back)
                    ab_op = {7'b011_0111, mode[1:0], 2'b11, mode[2]};  // AB + {FF, DB} + 1
                else
                    ab_op = {7'b011_0110, mode[1:0], 2'b11, mode[2]};  // Forward or not taken
            end
            4'd8:  ab_op = {7'b000_0001, mode[1:0], 2'b00, mode[2]};   // {01, SP}, keep PC
            4'd9:  ab_op = {7'b111_0001, mode[1:0], 2'b00, mode[2]};   // {01, SP}, PC+1
            4'd10: ab_op = {7'b001_1110, mode[1:0], 2'b01, mode[2]};   // {DB, AHL+REG}, keep PC
            4'd11: ab_op = {7'b010_0001, mode[1:0], 2'b00, mode[2]};   // {01, SP}
            4'd12: ab_op = {7'b001_0110, mode[1:0], 2'b11, mode[2]};   // AB+1, keep PC
            4'd14: ab_op = {7'b001_1110, mode[1:0], 2'b01, mode[2]};   // Target + 1
            default: ab_op = {7'b001_0110, mode[1:0], 2'b11, mode[2]}; // Hold AB
        endcase
    end

endmodule

// File: rtl/exec_op_gen.sv
`timescale 1ns/10ps

module exec_op_gen import cpu_ctl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ctl_state_t state,
    input  logic       add_x,
    input  logic       add_y,
    input  logic       ld,
    input  logic       st,
    input  reg_src_t   src,
    input  reg_dst_t   dst,
    input  alu_fn_t    alu_fn,
    output reg_op_t    reg_op,
    output alu_op_t    alu_op,
    output do_sel_t    do_op,
    output logic       we             // Memory write, one cycle late
);

    reg_src_t idx_src;

    // Index for zero page and absolute offsets
    assign idx_src = add_x ? SRC_X : (add_y ? SRC_Y : SRC_Z);

    always_comb begin
        case (state)
            PUSH, JSR0, JSR1,
            PULL, RTS0, RTS1: reg_op = {1'b1, DST_S, SRC_S};              // Update SP
            IND0:             reg_op = {1'b0, DST_X, add_x ? SRC_X : SRC_Z};  // Pre-index
            IND2:             reg_op = {1'b0, DST_X, add_y ? SRC_Y : SRC_Z};  // Post-index
            ZERO, ABS1:       reg_op = {1'b0, DST_X, idx_src};
            SYNC:             reg_op = {ld, dst, src};                      // Result of last opcode
            DATA:             reg_op = {1'b0, dst, src};                    // Store source
            default:          reg_op = {1'b0, DST_X, SRC_Z};
        endcase
    end

    always_comb begin
        case (state)
            PUSH, JSR0, JSR1: alu_op = STACK_DEC;
            PULL, RTS0, RTS1: alu_op = STACK_INC;
            IMM0, RDWR:       alu_op = ALU_OP_LDM;                          // Capture M
            SYNC:             alu_op = {2'b00, alu_fn};
            DATA: begin
                if (st)
                    alu_op = ALU_OP_STORE;
                else
                    alu_op = {2'b10, alu_fn};                               // Load or RMW
            end
            default:          alu_op = ALU_OP_NOP;
        endcase
    end

    always_comb begin
        case (state)
            JSR1:    do_op = DO_PCH;          // Return address high first
            JSR2:    do_op = DO_PCL;
            default: do_op = DO_ALU;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            we <= 1'b0;
        else
            we <= state inside {JSR0, JSR1, PUSH, RDWR};
    end

endmodule

// File: rtl/cpu_ctl.sv
`timescale 1ns/10ps

module cpu_ctl import cpu_ctl_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  opcode_t db,
    input  logic    cond,
    output logic    sync,
    output logic    we,
    output ab_op_t  ab_op,
    output reg_op_t reg_op,
    output alu_op_t alu_op,
    output do_sel_t do_op
);

    ctl_state_t state;
    ctl_state_t entry_state;
    logic       abs1_done;
    logic       rmw;
    logic       jmp;
    logic       ind;
    logic       add_x;
    logic       add_y;
    logic       ld;
    logic       st;
    reg_src_t   src;
    reg_dst_t   dst;
    alu_fn_t    alu_fn;

    instr_decoder i_instr_decoder (
        .clk(clk), .reset(reset), .db(db), .sync(sync), .abs1_done(abs1_done),
        .entry_state(entry_state), .rmw(rmw), .jmp(jmp), .ind(ind),
        .add_x(add_x), .add_y(add_y), .ld(ld), .st(st),
        .src(src), .dst(dst), .alu_fn(alu_fn)
    );

    ctl_sequencer i_ctl_sequencer (
        .clk(clk), .reset(reset), .entry_state(entry_state),
        .ind(ind), .jmp(jmp), .rmw(rmw),
        .state(state), .sync(sync), .abs1_done(abs1_done)
    );

    addr_op_gen i_addr_op_gen (
        .state(state), .cond(cond), .db(db), .ab_op(ab_op)
    );

    exec_op_gen i_exec_op_gen (
        .clk(clk), .reset(reset), .state(state),
        .add_x(add_x), .add_y(add_y), .ld(ld), .st(st),
        .src(src), .dst(dst), .alu_fn(alu_fn),
        .reg_op(reg_op), .alu_op(alu_op), .do_op(do_op), .we(we)
    );

endmodule

// File: verification/cpu_ctl_vectors.svh
`ifndef CPU_CTL_VECTORS_SVH
`define CPU_CTL_VECTORS_SVH

task automatic load_vectors();
    // Opcode, operand (0 = random), cond, cycles sync to sync, we-high cycles,
    // {ld, dst, src} expected on reg_op at the following sync
    vecs.push_back(vec_t'{8'ha9, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_10_0111});  // LDA #
    vecs.push_back(vec_t'{8'ha2, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_00_0111});  // LDX #
    vecs.push_back(vec_t'{8'ha0, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_01_0111});  // LDY #
    vecs.push_back(vec_t'{8'h09, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_10_0010});  // ORA #
    vecs.push_back(vec_t'{8'h29, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_10_0010});  // AND #
    vecs.push_back(vec_t'{8'h49, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_10_0010});  // EOR #
    vecs.push_back(vec_t'{8'h69, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_10_0010});  // ADC #
    vecs.push_back(vec_t'{8'he9, 8'h00, 1'b0, 4'd2, 4'd0, 7'b1_10_0010});  // SBC #
    vecs.push_back(vec_t'{8'hc9, 8'h00, 1'b0, 4'd2, 4'd0, 7'b0_10_0010});  // CMP #, no write
    vecs.push_back(vec_t'{8'ha5, 8'h00, 1'b0, 4'd3, 4'd0, 7'b1_10_0111});  // LDA zp
    vecs.push_back(vec_t'{8'hb5, 8'h00, 1'b0, 4'd3, 4'd0, 7'b1_10_0111});  // LDA zp,X
    vecs.push_back(vec_t'{8'hb6, 8'h00, 1'b0, 4'd3, 4'd0, 7'b1_00_0111});  // LDX zp,Y
    vecs.push_back(vec_t'{8'h65, 8'h00, 1'b0, 4'd3, 4'd0, 7'b1_10_0010});  // ADC zp
    vecs.push_back(vec_t'{8'h06, 8'h00, 1'b0, 4'd4, 4'd1, 7'b0_00_0101});  // ASL zp
    vecs.push_back(vec_t'{8'h16, 8'h00, 1'b0, 4'd4, 4'd1, 7'b0_00_0101});  // ASL zp,X
    vecs.push_back(vec_t'{8'he6, 8'h00, 1'b0, 4'd4, 4'd1, 7'b0_00_0101});  // INC zp
    vecs.push_back(vec_t'{8'had, 8'h00, 1'b0, 4'd4, 4'd0, 7'b1_10_0111});  // LDA abs
    vecs.push_back(vec_t'{8'hbd, 8'h00, 1'b0, 4'd4, 4'd0, 7'b1_10_0111});  // LDA abs,X
    vecs.push_back(vec_t'{8'hb9, 8'h00, 1'b0, 4'd4, 4'd0, 7'b1_10_0111});  // LDA abs,Y
    vecs.push_back(vec_t'{8'hee, 8'h00, 1'b0, 4'd5, 4'd1, 7'b0_00_0101});  // INC abs
    vecs.push_back(vec_t'{8'ha1, 8'h00, 1'b0, 4'd5, 4'd0, 7'b1_10_0111});  // LDA (zp,X)
    vecs.push_back(vec_t'{8'hb2, 8'h00, 1'b0, 4'd5, 4'd0, 7'b1_10_0111});  // LDA (zp)
    vecs.push_back(vec_t'{8'hb1, 8'h00, 1'b0, 4'd5, 4'd0, 7'b1_10_0111});  // LDA (zp),Y
    vecs.push_back(vec_t'{8'h4c, 8'h00, 1'b0, 4'd3, 4'd0, 7'b0_00_0111});  // JMP abs
    vecs.push_back(vec_t'{8'h6c, 8'h00, 1'b0, 4'd5, 4'd0, 7'b0_00_0111});  // JMP (abs)
    vecs.push_back(vec_t'{8'h7c, 8'h00, 1'b0, 4'd5, 4'd0, 7'b0_00_0111});  // JMP (abs,X)
    vecs.push_back(vec_t'{8'h48, 8'h00, 1'b0, 4'd3, 4'd1, 7'b0_00_0010});  // PHA
    vecs.push_back(vec_t'{8'h68, 8'h00, 1'b0, 4'd3, 4'd0, 7'b1_10_0111});  // PLA
    vecs.push_back(vec_t'{8'h20, 8'h00, 1'b0, 4'd5, 4'd2, 7'b0_00_0111});  // JSR, PCH then PCL
    vecs.push_back(vec_t'{8'h60, 8'h00, 1'b0, 4'd4, 4'd0, 7'b0_00_0111});  // RTS
    vecs.push_back(vec_t'{8'h80, 8'h00, 1'b0, 4'd2, 4'd0, 7'b0_00_0111});  // BRA not taken
    vecs.push_back(vec_t'{8'h80, 8'h00, 1'b1, 4'd2, 4'd0, 7'b0_00_0111});  // BRA random offset
    vecs.push_back(vec_t'{8'h80, 8'h00, 1'b1, 4'd2, 4'd0, 7'b0_00_0111});
    vecs.push_back(vec_t'{8'h80, 8'hf0, 1'b1, 4'd2, 4'd0, 7'b0_00_0111});  // Backward
    vecs.push_back(vec_t'{8'h80, 8'h7f, 1'b1, 4'd2, 4'd0, 7'b0_00_0111});  // Forward
    vecs.push_back(vec_t'{8'h80, 8'h80, 1'b0, 4'd2, 4'd0, 7'b0_00_0111});  // Negative, not taken
    vecs.push_back(vec_t'{8'hca, 8'h00, 1'b0, 4'd1, 4'd0, 7'b1_00_0000});  // DEX
    vecs.push_back(vec_t'{8'he8, 8'h00, 1'b0, 4'd1, 4'd0, 7'b1_00_0000});  // INX
    vecs.push_back(vec_t'{8'h00, 8'h00, 1'b0, 4'd1, 4'd0, 7'b0_00_0111});  // Former BRK
    vecs.push_back(vec_t'{8'h40, 8'h00, 1'b0, 4'd1, 4'd0, 7'b0_00_0111});  // Former RTI
    vecs.push_back(vec_t'{8'hea, 8'h00, 1'b0, 4'd1, 4'd0, 7'b0_00_0111});  // Unlisted
endtask

`endif

// File: verification/cpu_ctl_tb.sv
`timescale 1ns/10ps

module cpu_ctl_tb;

    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] operand;                             // 0 picks a random byte
        logic       cond_val;                            // Branch condition input
        logic [3:0] len;                                 // Cycles from sync to next sync
        logic [3:0] we_cnt;                              // Cycles with we high
        logic [6:0] reg_op;                              // {ld, dst, src} at next sync
    } vec_t;

    localparam logic [31:0] SEED        = 32'h3a380ce1;
    localparam logic [3:0]  MAX_CYCLES  = 4'd12;         // Longest flow is 5
    localparam logic [7:0]  OP_FILL     = 8'hea;         // Unlisted, follows the table
    localparam logic [11:0] AB_BRA_BACK = 12'b011_0111_11_11_1;   // AB + {FF, DB} + 1
    localparam logic [11:0] AB_BRA_FWD  = 12'b011_0110_11_11_1;   // Forward or not taken
    localparam logic [1:0]  DO_PCL_SEL  = 2'd2;
    localparam logic [1:0]  DO_PCH_SEL  = 2'd3;
    localparam logic [8:0]  ALU_S_DEC   = 9'b0_0_00_101_00;      // S - 1
    localparam logic [8:0]  ALU_S_INC   = 9'b0_0_00_100_01;      // S + 1

    logic        clk = 1'b0;
    logic        reset;
    logic [7:0]  db;
    logic        cond;
    logic        sync;
    logic        we;
    logic [11:0] ab_op;
    logic [6:0]  reg_op;
    logic [8:0]  alu_op;
    logic [1:0]  do_op;
    vec_t        vecs[$];

    `include "cpu_ctl_vectors.svh"

    cpu_ctl i_cpu_ctl (
        .clk(clk), .reset(reset), .db(db), .cond(cond),
        .sync(sync), .we(we), .ab_op(ab_op), .reg_op(reg_op),
        .alu_op(alu_op), .do_op(do_op)
    );

    always #20 clk = ~clk;                               // 40 ns period

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        abort_run();
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        abort_run();
    endtask

    // Register write of the instruction that just ended
    task automatic check_reg_op(input vec_t v);
        assert (reg_op === v.reg_op)
            else report_mismatch($sformatf("opcode %h: reg_op %b at sync, expected %b",
                                           v.opcode, reg_op, v.reg_op));
    endtask

    // Enters and leaves at the negedge of a sync cycle
    task automatic run_instruction(input vec_t v, input logic [7:0] next_opcode);
        logic [3:0]  cycles;
        logic [3:0]  we_seen;
        logic [7:0]  operand;
        logic [11:0] exp_ab;
        logic        got_sync;
        cycles   = 4'd1;                                 // Sync cycle counts
        we_seen  = {3'b000, we};
        operand  = (v.operand == 8'h00) ? 8'($urandom) : v.operand;
        got_sync = 1'b0;
        while (!got_sync && cycles < MAX_CYCLES) begin
            @(posedge clk);
            if (cycles >= v.len)
                db <= next_opcode;                       // Fetch expected here
            else if (cycles == 4'd1)
                db <= operand;
            else
                db <= 8'($urandom);                      // Later operand bytes
            cond <= v.cond_val;
            @(negedge clk);
            if (sync) begin
                got_sync = 1'b1;
            end else begin
                if (v.opcode == 8'h80 && cycles == 4'd1) begin
                    exp_ab = (v.cond_val && operand[7]) ? AB_BRA_BACK : AB_BRA_FWD;
                    assert (ab_op === exp_ab)
                        else report_mismatch($sformatf("BRA cond %b offset %h: ab_op %b, expected %b",
                                                       v.cond_val, operand, ab_op, exp_ab));
                end
                if (v.opcode == 8'h20 && cycles == 4'd2) begin
                    assert (do_op === DO_PCH_SEL)        // Return address high byte
                        else report_mismatch($sformatf("JSR cycle 3: do_op %0d, expected PCH", do_op));
                end
                if (v.opcode == 8'h20 && cycles == 4'd3) begin
                    assert (do_op === DO_PCL_SEL)
                        else report_mismatch($sformatf("JSR cycle 4: do_op %0d, expected PCL", do_op));
                end
                if ((v.opcode == 8'h20 && cycles <= 4'd2) ||
                    (v.opcode == 8'h48 && cycles == 4'd1)) begin
                    assert (alu_op === ALU_S_DEC)        // Stack writes pre-decrement S
                        else report_mismatch($sformatf("opcode %h cycle %0d: alu_op %b, expected %b",
                                                       v.opcode, cycles + 4'd1, alu_op, ALU_S_DEC));
                end
                if ((v.opcode == 8'h60 && cycles <= 4'd2) ||
                    (v.opcode == 8'h68 && cycles == 4'd1)) begin
                    assert (alu_op === ALU_S_INC)        // Stack reads increment S
                        else report_mismatch($sformatf("opcode %h cycle %0d: alu_op %b, expected %b",
                                                       v.opcode, cycles + 4'd1, alu_op, ALU_S_INC));
                end
                we_seen = we_seen + {3'b000, we};
                cycles  = cycles + 4'd1;
            end
        end
        assert (got_sync)
            else report_timeout($sformatf("no sync within %0d cycles of opcode %h",
                                          MAX_CYCLES, v.opcode));
        assert (cycles == v.len)
            else report_mismatch($sformatf("opcode %h: took %0d cycles, expected %0d",
                                           v.opcode, cycles, v.len));
        assert (we_seen == v.we_cnt)
            else report_mismatch($sformatf("opcode %h: we high %0d cycles, expected %0d",
                                           v.opcode, we_seen, v.we_cnt));
    endtask

    initial begin
        int         i;
        logic [7:0] next_opcode;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(SEED));
        load_vectors();
        reset = 1'b1;
        db    = vecs[0].opcode;                          // Ready for the first fetch
        cond  = 1'b0;
        for (i = 0; i < 10; i++) begin                   // Reset held 10 cycles
            @(negedge clk);
            assert (sync === 1'b0 && we === 1'b0)
                else report_mismatch($sformatf("sync %b we %b during reset", sync, we));
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);                                  // INIT
        assert (sync === 1'b0 && we === 1'b0)
            else report_mismatch($sformatf("sync %b we %b one cycle after reset", sync, we));
        @(negedge clk);                                  // First SYNC
        assert (sync === 1'b1)
            else report_mismatch("sync not high two cycles after reset");
        for (i = 0; i < vecs.size(); i++) begin
            if (i > 0)
                check_reg_op(vecs[i - 1]);
            next_opcode = (i + 1 < vecs.size()) ? vecs[i + 1].opcode : OP_FILL;
            run_instruction(vecs[i], next_opcode);
        end
        check_reg_op(vecs[vecs.size() - 1]);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
rtl/cpu_ctl_pkg.sv
rtl/instr_decoder.sv
rtl/ctl_sequencer.sv
rtl/addr_op_gen.sv
rtl/exec_op_gen.sv
rtl/cpu_ctl.sv
verification/cpu_ctl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cpu_ctl testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timescale 1ns/10ps --top-module cpu_ctl_tb -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vcpu_ctl_tb > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -qx "Result: PASSED" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
